/* Makefile */
# Verilator build and run for the FFT data buffer testbench

VERILATOR ?= verilator
TOP       ?= fft_buffer_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the twiddle table is read at run time, relative to the project root
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
hdl/fft_buf_pkg.sv
hdl/fft_sample_ram.sv
hdl/fft_twiddle_rom.sv
hdl/fft_operand_pairer.sv
hdl/fft_result_streamer.sv
hdl/fft_buffer_top.sv
verif/fft_buffer_tb.sv

/* hdl/fft_buf_pkg.sv */
package fft_buf_pkg;

   localparam int SAMPLE_W  = 29;        // one real or imaginary part
   localparam int FFT_N     = 16;
   localparam int ADDR_W    = 4;
   localparam int TW_W      = 14;        // Q1.12 twiddle part
   localparam int TW_ONE    = 4096;      // 1.0 in Q1.12
   localparam int TW_DEPTH  = 8;         // angles k*pi/8, k = 0..7
   localparam int TW_ADDR_W = 3;

   // operand pairer slots
   localparam logic SLOT_FIRST  = 1'b0;
   localparam logic SLOT_SECOND = 1'b1;

   // result streamer states
   localparam logic ST_IDLE   = 1'b0;
   localparam logic ST_STREAM = 1'b1;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] re;
      logic signed [SAMPLE_W-1:0] im;
   } cplx_t;

   // shared by the load port and the write-back port
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      cplx_t             data;
   } wr_req_t;

   typedef struct packed {
      logic                 valid;
      logic [ADDR_W-1:0]    addr;
      logic [TW_ADDR_W-1:0] tw_addr;  // angle index for this read
   } rd_req_t;

   // the table stores raw words, the datapath reads cos/sin
   typedef union packed {
      logic [2*TW_W-1:0] raw;
      struct packed {
         logic signed [TW_W-1:0] cos;
         logic signed [TW_W-1:0] sin;
      } cs;
   } twiddle_u;

   typedef struct packed {
      cplx_t    a;                    // first read of the pair
      cplx_t    b;                    // second read
      twiddle_u tw;                   // twiddle of the second read
   } bfly_operands_t;

endpackage

/* hdl/fft_buffer_top.sv */
`timescale 1ns/100ps

module fft_buffer_top
   import fft_buf_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  wr_req_t        load_i,        // natural input index
   input  wr_req_t        wb_i,
   input  rd_req_t        rd_i,
   input  logic           finish_i,
   input  logic           done_i,
   output bfly_operands_t operands_o,
   output logic           pair_valid_o,
   output cplx_t          out_data_o,
   output logic           out_valid_o
);

   cplx_t    rd_data;
   logic     rd_valid;
   twiddle_u tw;

   // memory and table both see the same read strobe
   fft_sample_ram u_sample_ram (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_i     (load_i),
      .wb_i       (wb_i),
      .rd_i       (rd_i),
      .rd_data_o  (rd_data),
      .rd_valid_o (rd_valid)
   );

   fft_twiddle_rom u_twiddle_rom (
      .clk  (clk),
      .rd_i (rd_i),
      .tw_o (tw)
   );

   // butterfly operands during the transform
   fft_operand_pairer u_operand_pairer (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_data_i    (rd_data),
      .rd_valid_i   (rd_valid),
      .tw_i         (tw),
      .operands_o   (operands_o),
      .pair_valid_o (pair_valid_o)
   );

   // final output once the transform is done
   fft_result_streamer u_result_streamer (
      .clk         (clk),
      .rst_n       (rst_n),
      .finish_i    (finish_i),
      .done_i      (done_i),
      .rd_data_i   (rd_data),
      .rd_valid_i  (rd_valid),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o)
   );

endmodule

/* hdl/fft_operand_pairer.sv */
`timescale 1ns/100ps

module fft_operand_pairer
   import fft_buf_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  cplx_t          rd_data_i,
   input  logic           rd_valid_i,
   input  twiddle_u       tw_i,
   output bfly_operands_t operands_o,
   output logic           pair_valid_o
);

   logic           slot_q;
   cplx_t          first_q;              // sample from the first slot
   bfly_operands_t ops_q;                // last emitted pair

   // second sample and its twiddle arrive this cycle
   assign pair_valid_o = (slot_q == SLOT_SECOND) && rd_valid_i;

   always_comb begin
      if (pair_valid_o) begin
         operands_o.a  = first_q;
         operands_o.b  = rd_data_i;
         operands_o.tw = tw_i;
      end else begin
         operands_o = ops_q;              // hold between pairs
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_q <= SLOT_FIRST;
      end else begin
         case (slot_q)
            SLOT_FIRST: begin
               if (rd_valid_i) begin
                  slot_q <= SLOT_SECOND;
               end
            end
            SLOT_SECOND: begin
               slot_q <= SLOT_FIRST;       // back to first, pair or not
            end
            default: begin
               slot_q <= SLOT_FIRST;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (slot_q == SLOT_FIRST && rd_valid_i) begin
         first_q <= rd_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (pair_valid_o) begin
         ops_q <= operands_o;
      end
   end

endmodule

/* hdl/fft_result_streamer.sv */
`timescale 1ns/100ps

module fft_result_streamer
   import fft_buf_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  finish_i,
   input  logic  done_i,
   input  cplx_t rd_data_i,
   input  logic  rd_valid_i,
   output cplx_t out_data_o,
   output logic  out_valid_o
);

   logic state_q;
   logic fwd;

   // done_i also drops whatever is still in flight
   assign fwd = (state_q == ST_STREAM) && !done_i && rd_valid_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= ST_IDLE;
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= fwd;
         case (state_q)
            ST_IDLE: begin
               if (finish_i) begin
                  state_q <= ST_STREAM;    // transform complete
               end
            end
            ST_STREAM: begin
               if (done_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fwd) begin
         out_data_o <= rd_data_i;
      end
   end

endmodule

/* hdl/fft_sample_ram.sv */
`timescale 1ns/100ps

module fft_sample_ram
   import fft_buf_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  wr_req_t load_i,
   input  wr_req_t wb_i,
   input  rd_req_t rd_i,
   output cplx_t   rd_data_o,
   output logic    rd_valid_o
);

   wr_req_t           sel_req;
   logic              wr_vld_q;
   logic [ADDR_W-1:0] wr_addr_q;
   cplx_t             wr_data_q;

   cplx_t mem [FFT_N];

   // mirror the index bits, 0001 -> 1000
   function automatic logic [ADDR_W-1:0] bit_rev(input logic [ADDR_W-1:0] idx);
      logic [ADDR_W-1:0] rev;
      for (int i = 0; i < ADDR_W; i++) begin
         rev[i] = idx[ADDR_W-1-i];
      end
      return rev;
   endfunction

   // load wins, a colliding write-back is dropped
   always_comb begin
      if (load_i.valid) begin
         sel_req      = load_i;
         sel_req.addr = bit_rev(load_i.addr);   // store in bit-reversed order
      end else begin
         sel_req = wb_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_vld_q <= 1'b0;
      end else begin
         wr_vld_q <= sel_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (sel_req.valid) begin
         wr_addr_q <= sel_req.addr;
         wr_data_q <= sel_req.data;
      end
   end

   // second edge of the write path
   always_ff @(posedge clk) begin
      if (wr_vld_q) begin
         mem[wr_addr_q] <= wr_data_q;
      end
   end

   // registered read, data held until the next read
   always_ff @(posedge clk) begin
      if (rd_i.valid) begin
         rd_data_o <= mem[rd_i.addr];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_i.valid;         // one cycle per read
      end
   end

endmodule

/* hdl/fft_twiddle.mem */
// cos[27:14] sin[13:0], Q1.12, sin column holds -sin, angle k*pi/8 for k = 0..7
4000000
3B239E1
2D434B0
187F138
0003000
E787138
D2C34B0
C4E39E1

/* hdl/fft_twiddle_rom.sv */
`timescale 1ns/100ps

module fft_twiddle_rom
   import fft_buf_pkg::*;
(
   input  logic     clk,
   input  rd_req_t  rd_i,
   output twiddle_u tw_o
);

   // cos in the upper half, sin in the lower half of each word
   logic [2*TW_W-1:0] rom [TW_DEPTH];

   initial begin
      $readmemh("hdl/fft_twiddle.mem", rom);
   end

   // same latency as the sample read
   always_ff @(posedge clk) begin
      if (rd_i.valid) begin
         tw_o.raw <= rom[rd_i.tw_addr];
      end
   end

endmodule

/* verif/fft_buffer_tb.sv */
`timescale 1ns/100ps

module fft_buffer_tb
   import fft_buf_pkg::*;
();

   localparam int  TIMEOUT_CYCLES = 2000;        // far above the length of all tests
   localparam real PI             = 3.14159265358979;

   logic           clk;
   logic           rst_n;
   wr_req_t        load_i;
   wr_req_t        wb_i;
   rd_req_t        rd_i;
   logic           finish_i;
   logic           done_i;
   bfly_operands_t operands_o;
   logic           pair_valid_o;
   cplx_t          out_data_o;
   logic           out_valid_o;

   cplx_t exp_mem [FFT_N];                       // expected contents by memory address

   int err_count   = 0;
   int check_count = 0;
   int tests_run   = 0;
   int cycle_count = 0;

   fft_buffer_top uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .load_i       (load_i),
      .wb_i         (wb_i),
      .rd_i         (rd_i),
      .finish_i     (finish_i),
      .done_i       (done_i),
      .operands_o   (operands_o),
      .pair_valid_o (pair_valid_o),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                     // 4 ns period
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests_run++;
      $display("%-14s finished, %0d mismatches", name, err_count - start_errors);
   endtask

   function automatic cplx_t random_sample();
      logic [31:0] r;
      cplx_t       s;
      r    = $urandom;
      s.re = r[SAMPLE_W-1:0];
      r    = $urandom;
      s.im = r[SAMPLE_W-1:0];
      return s;
   endfunction

   // input index 0001 lands at memory address 1000
   function automatic logic [ADDR_W-1:0] reversed_index(input logic [ADDR_W-1:0] idx);
      return {idx[0], idx[1], idx[2], idx[3]};
   endfunction

   function automatic int round_real(input real r);
      if (r >= 0.0) begin
         return $rtoi(r + 0.5);
      end else begin
         return -$rtoi(0.5 - r);
      end
   endfunction

   function automatic twiddle_u twiddle_for_angle(input int k);
      real      angle;
      int       c;
      int       s;
      twiddle_u t;
      angle     = PI * k / 8.0;
      c         = round_real(TW_ONE * $cos(angle));
      s         = round_real(-TW_ONE * $sin(angle));
      t.cs.cos  = c[TW_W-1:0];
      t.cs.sin  = s[TW_W-1:0];
      return t;
   endfunction

   // reads addr_a then addr_a+1 and expects the pair two cycles after the first
   task automatic read_pair(input logic [ADDR_W-1:0] addr_a, input int k);
      rd_req_t           r;
      logic [ADDR_W-1:0] addr_b;
      bfly_operands_t    want;
      addr_b    = addr_a + 1'b1;
      want.a    = exp_mem[addr_a];
      want.b    = exp_mem[addr_b];
      want.tw   = twiddle_for_angle(k);
      r.valid   = 1'b1;
      r.addr    = addr_a;
      r.tw_addr = TW_ADDR_W'(k + 1);              // other angle on the first read
      @(posedge clk);
      rd_i <= r;
      r.addr    = addr_b;
      r.tw_addr = TW_ADDR_W'(k);
      @(posedge clk);
      rd_i <= r;
      @(negedge clk);
      check_value("pair_valid_o", 64'd0, 64'(pair_valid_o));  // first sample only
      @(posedge clk);
      rd_i <= '0;
      @(negedge clk);
      check_value("pair_valid_o", 64'd1, 64'(pair_valid_o));
      check_value("operands_o.a", 64'(want.a), 64'(operands_o.a));
      check_value("operands_o.b", 64'(want.b), 64'(operands_o.b));
      check_value("operands_o.tw.cos", 64'(want.tw.cs.cos), 64'(operands_o.tw.cs.cos));
      check_value("operands_o.tw.sin", 64'(want.tw.cs.sin), 64'(operands_o.tw.cs.sin));
      check_value("out_valid_o", 64'd0, 64'(out_valid_o));
      @(posedge clk);
      @(negedge clk);
      check_value("pair_valid_o", 64'd0, 64'(pair_valid_o));  // one cycle only
      check_value("operands_o.a", 64'(want.a), 64'(operands_o.a));  // held after the pair
      check_value("operands_o.b", 64'(want.b), 64'(operands_o.b));
      check_value("operands_o.tw", 64'(want.tw.raw), 64'(operands_o.tw.raw));
   endtask

   // back-to-back reads of every address with output due two cycles later
   task automatic stream_burst(input bit expect_out);
      rd_req_t r;
      cplx_t   want;
      for (int c = 0; c < FFT_N + 2; c++) begin
         r = '0;
         if (c < FFT_N) begin
            r.valid = 1'b1;
            r.addr  = ADDR_W'(c);
         end
         @(posedge clk);
         rd_i <= r;
         @(negedge clk);
         if (expect_out && c >= 2) begin
            want = exp_mem[ADDR_W'(c - 2)];
            check_value("out_valid_o", 64'd1, 64'(out_valid_o));
            check_value("out_data_o", 64'(want), 64'(out_data_o));
         end else begin
            check_value("out_valid_o", 64'd0, 64'(out_valid_o));
         end
      end
   endtask

   task automatic reset_state_test();
      int start;
      start = err_count;
      repeat (6) begin
         @(negedge clk);
         check_value("pair_valid_o", 64'd0, 64'(pair_valid_o));
         check_value("out_valid_o", 64'd0, 64'(out_valid_o));
      end
      report_test("reset_state", start);
   endtask

   task automatic load_bitrev_test();
      int      start;
      wr_req_t ld;
      start = err_count;
      for (int i = 0; i < FFT_N; i++) begin
         ld.valid = 1'b1;
         ld.addr  = ADDR_W'(i);                   // natural index
         ld.data  = random_sample();
         @(posedge clk);
         load_i <= ld;
         exp_mem[reversed_index(ld.addr)] = ld.data;
      end
      @(posedge clk);
      load_i <= '0;
      @(posedge clk);                             // let the last write land
      for (int a = 0; a < FFT_N; a += 2) begin
         read_pair(ADDR_W'(a), a / 2);
      end
      report_test("load_bitrev", start);
   endtask

   task automatic writeback_test();
      int      start;
      wr_req_t wb;
      wr_req_t ld;
      start = err_count;
      wb.valid = 1'b1;
      wb.addr  = ADDR_W'(5);
      wb.data  = random_sample();
      @(posedge clk);
      wb_i <= wb;
      exp_mem[wb.addr] = wb.data;
      @(posedge clk);
      wb_i <= '0;
      @(posedge clk);
      read_pair(ADDR_W'(4), 1);                   // b is address 5
      ld.valid = 1'b1;
      ld.addr  = ADDR_W'(1);                      // lands at address 8
      ld.data  = random_sample();
      wb.addr  = ADDR_W'(3);
      wb.data  = random_sample();
      @(posedge clk);
      load_i <= ld;
      wb_i   <= wb;                               // lost against the load
      exp_mem[reversed_index(ld.addr)] = ld.data;
      @(posedge clk);
      load_i <= '0;
      wb_i   <= '0;
      @(posedge clk);
      read_pair(ADDR_W'(2), 2);                   // address 3 keeps old data
      read_pair(ADDR_W'(8), 3);
      report_test("writeback", start);
   endtask

   task automatic twiddle_test();
      int start;
      start = err_count;
      for (int k = 0; k < TW_DEPTH; k++) begin
         read_pair(ADDR_W'(6), k);
      end
      report_test("twiddles", start);
   endtask

   task automatic streaming_test();
      int start;
      start = err_count;
      stream_burst(1'b0);                         // still in the transform
      @(posedge clk);
      finish_i <= 1'b1;
      @(posedge clk);
      finish_i <= 1'b0;
      stream_burst(1'b1);
      @(posedge clk);
      done_i <= 1'b1;
      @(posedge clk);
      done_i <= 1'b0;
      stream_burst(1'b0);                         // back to idle
      report_test("streaming", start);
   endtask

   initial begin
      void'($urandom(32'h90f4313e));
      rst_n    = 1'b0;
      load_i   = '0;
      wb_i     = '0;
      rd_i     = '0;
      finish_i = 1'b0;
      done_i   = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      reset_state_test();
      load_bitrev_test();
      writeback_test();
      twiddle_test();
      streaming_test();
      $display("tests run: %0d, checks: %0d, mismatches: %0d",
               tests_run, check_count, err_count);
      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
